//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_async_fifo
FILELIST  = async_fifo.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

//--- async_fifo.f
+incdir+rtl
rtl/async_fifo_pkg.sv
rtl/fifo_dpram.sv
rtl/fifo_wr_ctrl.sv
rtl/fifo_rd_ctrl.sv
rtl/async_fifo.sv
dv/tb_clkgen.sv
dv/tb_async_fifo.sv

//--- dv/async_fifo_trace.txt
# Columns: opcode operand. W write hex, R read expect hex, U read while empty expect hex,
# I idle rd_clk cycles, F flags {full,afull,empty,aempty} hex, Q rd_data hex,
# X random cycles, M flags from model, D drain model, E end of test with name.
F 3
Q 00
E reset_state
W 10
W 11
W 12
W 13
W 14
W 15
W 16
W 17
W 18
W 19
W 1a
W 1b
W 1c
W 1d
W 1e
W 1f
W ee
I 5
F c
E fill_overflow
R 10
I 5
F 4
R 11
I 5
F 4
R 12
I 5
F 0
E thresholds_high
R 13
R 14
R 15
R 16
R 17
R 18
R 19
R 1a
R 1b
R 1c
I 5
F 0
R 1d
I 5
F 1
R 1e
I 5
F 1
E thresholds_low
R 1f
I 5
F 3
E ordered_drain
U 1f
I 2
F 3
Q 1f
E underflow_hold
X 200
I 6
M 0
D 0
I 5
F 3
E random_interleave

//--- dv/tb_async_fifo.sv
`timescale 1ns/1ps
`include "async_fifo_consts.svh"

module tb_async_fifo;

  localparam logic [31:0] SEED = 32'hdf31_6330;

  logic                  wr_clk;
  logic                  rd_clk;
  logic                  wr_rst_n;
  logic                  rd_rst_n;
  logic                  wr_en;
  logic                  rd_en;
  async_fifo_pkg::data_t wr_data;
  async_fifo_pkg::data_t rd_data;
  logic                  full;
  logic                  afull;
  logic                  empty;
  logic                  aempty;

  async_fifo_pkg::data_t model_q[$];
  string                 op_q[$];
  string                 arg_q[$];
  int                    err_cnt;
  int                    tests_ok;
  int                    tests_bad;
  int                    cycle_cnt;
  int                    cycle_limit;

  tb_clkgen clkgen_i (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_rst_n (rd_rst_n)
  );

  async_fifo dut_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic take_head(output async_fifo_pkg::data_t head);
    if (model_q.size() == 0) begin
      $display("At %0t ns the DUT accepted a read while the model held no data", $time);
      err_cnt++;
      head = '0;
    end else begin
      head = model_q.pop_front();
    end
  endtask

  // Full and empty only move on rising edges, so the falling edge sees the deciding value.
  task automatic drive_write(input async_fifo_pkg::data_t data);
    @(negedge wr_clk);
    wr_en   = 1'b1;
    wr_data = data;
    if (!full) begin
      model_q.push_back(data);
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  task automatic drive_read(input bit use_trace, input logic [31:0] exp);
    async_fifo_pkg::data_t head;
    @(negedge rd_clk);
    while (empty) begin
      @(negedge rd_clk);
    end
    rd_en = 1'b1;
    take_head(head);
    if (use_trace) begin
      check_val("trace_data", 32'(head), exp);
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
    check_val("rd_data", 32'(rd_data), 32'(head));
  endtask

  task automatic read_while_empty(input logic [31:0] exp);
    @(negedge rd_clk);
    check_val("empty", 32'(empty), 32'd1);
    rd_en = 1'b1;
    @(negedge rd_clk);
    rd_en = 1'b0;
    check_val("rd_data", 32'(rd_data), exp);
    check_val("empty", 32'(empty), 32'd1);
  endtask

  // Flag order is {full, afull, empty, aempty}.
  task automatic check_flags(input logic [3:0] exp);
    @(negedge wr_clk);
    check_val("full", 32'(full), 32'(exp[3]));
    check_val("afull", 32'(afull), 32'(exp[2]));
    check_val("empty", 32'(empty), 32'(exp[1]));
    check_val("aempty", 32'(aempty), 32'(exp[0]));
  endtask

  task automatic check_model_flags();
    int cnt;
    cnt = model_q.size();
    check_flags({cnt == `FIFO_DEPTH, cnt >= `FIFO_AFULL_LEVEL,
                 cnt == 0, cnt <= `FIFO_AEMPTY_LEVEL});
  endtask

  task automatic random_writes(input int cycles);
    logic [31:0] state;
    state = SEED;
    repeat (cycles) begin
      @(negedge wr_clk);
      state   = lcg_next(state);
      wr_en   = state[16];
      wr_data = state[31 -: `FIFO_DATA_WIDTH];
      if (state[16] && !full) begin
        model_q.push_back(state[31 -: `FIFO_DATA_WIDTH]);
      end
    end
    @(negedge wr_clk);
    wr_en = 1'b0;
  endtask

  // Reads run about three times in four.
  // Each read word is checked one edge later.
  task automatic random_reads(input int cycles);
    logic [31:0]           state;
    async_fifo_pkg::data_t exp_data;
    bit                    pending;
    state   = lcg_next(~SEED);
    pending = 1'b0;
    exp_data = '0;
    repeat (cycles) begin
      @(negedge rd_clk);
      if (pending) begin
        check_val("rd_data", 32'(rd_data), 32'(exp_data));
      end
      state   = lcg_next(state);
      rd_en   = (state[17:16] != 2'b00);
      pending = rd_en && !empty;
      if (pending) begin
        take_head(exp_data);
      end
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
    if (pending) begin
      check_val("rd_data", 32'(rd_data), 32'(exp_data));
    end
  endtask

  task automatic load_trace(input int fd, output int n_rand);
    string line;
    string op;
    string arg;
    int    n;
    n_rand = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%s %s", op, arg) == 2) begin
          op_q.push_back(op);
          arg_q.push_back(arg);
          if (op == "X") begin
            n_rand += arg.atoi();
          end
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_trace();
    string op;
    string arg;
    int    test_start;
    test_start = 0;
    for (int i = 0; i < op_q.size(); i++) begin
      op  = op_q[i];
      arg = arg_q[i];
      case (op)
        "W": drive_write(async_fifo_pkg::data_t'(arg.atohex()));
        "R": drive_read(1'b1, 32'(arg.atohex()));
        "U": read_while_empty(32'(arg.atohex()));
        "I": repeat (arg.atoi()) @(negedge rd_clk);
        "F": check_flags(4'(arg.atohex()));
        "M": check_model_flags();
        "Q": begin
          @(negedge rd_clk);
          check_val("rd_data", 32'(rd_data), 32'(arg.atohex()));
        end
        "D": begin
          while (model_q.size() > 0) begin
            drive_read(1'b0, 32'd0);
          end
        end
        "X": begin
          fork
            random_writes(arg.atoi());
            random_reads(arg.atoi());
          join
        end
        "E": begin
          if (err_cnt == test_start) begin
            tests_ok++;
            $display("Test %s: ok", arg);
          end else begin
            tests_bad++;
            $display("Test %s: %0d errors", arg, err_cnt - test_start);
          end
          test_start = err_cnt;
        end
        default: begin
          $display("Unknown trace opcode %s at entry %0d", op, i);
          err_cnt++;
        end
      endcase
    end
  endtask

  always @(posedge wr_clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d wr_clk cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int fd;
    int n_rand;
    wr_en       = 1'b0;
    wr_data     = '0;
    rd_en       = 1'b0;
    err_cnt     = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    cycle_cnt   = 0;
    cycle_limit = 100;
    fd = $fopen("dv/async_fifo_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open dv/async_fifo_trace.txt for reading");
      $display("TESTS FAILED");
      $finish;
    end else begin
      load_trace(fd, n_rand);
      cycle_limit = 12 * (op_q.size() + n_rand) + 100;
      wait (wr_rst_n && rd_rst_n);
      run_trace();
      $display("Summary: %0d tests clean, %0d tests with errors", tests_ok, tests_bad);
      if (tests_bad == 0 && err_cnt == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int WR_HALF = 20,
  parameter int RD_HALF = 28
) (
  output logic wr_clk,
  output logic rd_clk,
  output logic wr_rst_n,
  output logic rd_rst_n
);

  initial begin
    wr_clk = 1'b0;
    forever #(WR_HALF) wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #(RD_HALF) rd_clk = ~rd_clk;
  end

  // Each reset is held for two cycles and released on a falling edge.
  initial begin
    wr_rst_n = 1'b0;
    repeat (2) @(posedge wr_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
  end

  initial begin
    rd_rst_n = 1'b0;
    repeat (2) @(posedge rd_clk);
    @(negedge rd_clk);
    rd_rst_n = 1'b1;
  end

endmodule

//--- rtl/async_fifo.sv
`timescale 1ns/1ps
`include "async_fifo_consts.svh"

module async_fifo #(
  parameter int AFULL_LEVEL  = `FIFO_AFULL_LEVEL,
  parameter int AEMPTY_LEVEL = `FIFO_AEMPTY_LEVEL
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  async_fifo_pkg::data_t wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output async_fifo_pkg::data_t rd_data,
  output logic                  full,
  output logic                  afull,
  output logic                  empty,
  output logic                  aempty
);

  logic                  wr_en_mem;
  logic                  rd_en_mem;
  async_fifo_pkg::addr_t wr_addr;
  async_fifo_pkg::addr_t rd_addr;
  async_fifo_pkg::ptr_t  wr_ptr_gray;
  async_fifo_pkg::ptr_t  rd_ptr_gray;

  // Write domain.
  fifo_wr_ctrl #(
    .AFULL_LEVEL (AFULL_LEVEL)
  ) wr_ctrl_i (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .wr_en_mem   (wr_en_mem),
    .wr_addr     (wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull)
  );

  // Read domain.
  fifo_rd_ctrl #(
    .AEMPTY_LEVEL (AEMPTY_LEVEL)
  ) rd_ctrl_i (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .rd_en_mem   (rd_en_mem),
    .rd_addr     (rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

  fifo_dpram mem_i (
    .wr_clk    (wr_clk),
    .wr_en_mem (wr_en_mem),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en_mem (rd_en_mem),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

//--- rtl/async_fifo_consts.svh
`ifndef ASYNC_FIFO_CONSTS_SVH
`define ASYNC_FIFO_CONSTS_SVH

// Storage geometry.
`define FIFO_DATA_WIDTH 8
`define FIFO_DEPTH 16
`define FIFO_ADDR_WIDTH 4

// Flops in each pointer crossing.
`define FIFO_SYNC_STAGES 2

// Default flag thresholds, in words.
`define FIFO_AFULL_LEVEL 14
`define FIFO_AEMPTY_LEVEL 2

`endif

//--- rtl/async_fifo_pkg.sv
`include "async_fifo_consts.svh"

package async_fifo_pkg;

  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;

  // One extra bit tells a full FIFO from an empty one.
  typedef logic [`FIFO_ADDR_WIDTH:0] ptr_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];
    // Each binary bit folds in all Gray bits above it.
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

//--- rtl/fifo_dpram.sv
`timescale 1ns/1ps
`include "async_fifo_consts.svh"

module fifo_dpram (
  input  logic                  wr_clk,
  input  logic                  wr_en_mem,
  input  async_fifo_pkg::addr_t wr_addr,
  input  async_fifo_pkg::data_t wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en_mem,
  input  async_fifo_pkg::addr_t rd_addr,
  output async_fifo_pkg::data_t rd_data
);

  async_fifo_pkg::data_t mem [`FIFO_DEPTH];

  // Write port.
  always_ff @(posedge wr_clk) begin
    if (wr_en_mem) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read port holds the last word between reads.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en_mem) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- rtl/fifo_rd_ctrl.sv
`timescale 1ns/1ps
`include "async_fifo_consts.svh"

module fifo_rd_ctrl #(
  parameter int AEMPTY_LEVEL = `FIFO_AEMPTY_LEVEL
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  async_fifo_pkg::ptr_t  wr_ptr_gray,
  output logic                  rd_en_mem,
  output async_fifo_pkg::addr_t rd_addr,
  output async_fifo_pkg::ptr_t  rd_ptr_gray,
  output logic                  empty,
  output logic                  aempty
);

  localparam int TOP = `FIFO_ADDR_WIDTH;

  async_fifo_pkg::ptr_t rd_bin;
  async_fifo_pkg::ptr_t rd_bin_next;
  async_fifo_pkg::ptr_t rd_gray_next;
  async_fifo_pkg::ptr_t wr_gray_sync [`FIFO_SYNC_STAGES];
  async_fifo_pkg::ptr_t wr_gray_synced;
  async_fifo_pkg::ptr_t wr_bin_synced;
  async_fifo_pkg::ptr_t count_next;
  async_fifo_pkg::ptr_t rd_count;
  logic                 empty_next;
  logic                 aempty_next;

  // Reads while empty are ignored.
  assign rd_en_mem    = rd_en && !empty;
  assign rd_addr      = rd_bin[TOP-1:0];
  assign rd_bin_next  = rd_bin + async_fifo_pkg::ptr_t'(rd_en_mem);
  assign rd_gray_next = async_fifo_pkg::bin2gray(rd_bin_next);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_bin      <= rd_bin_next;
      rd_ptr_gray <= rd_gray_next;
    end
  end

  // Write pointer into this domain.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= '0;
      end
    end else begin
      wr_gray_sync[0] <= wr_ptr_gray;
      for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= wr_gray_sync[i-1];
      end
    end
  end

  assign wr_gray_synced = wr_gray_sync[`FIFO_SYNC_STAGES-1];
  assign wr_bin_synced  = async_fifo_pkg::gray2bin(wr_gray_synced);

  // Empty once the reader catches the visible write pointer.
  assign empty_next  = (rd_gray_next == wr_gray_synced);
  assign count_next  = wr_bin_synced - rd_bin_next;
  assign aempty_next = (count_next <= async_fifo_pkg::ptr_t'(AEMPTY_LEVEL));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_next;
      aempty <= aempty_next;
    end
  end

  // Words visible to the reader right now.
  assign rd_count = wr_bin_synced - rd_bin;

  rd_gray_step_a: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1
  );

  // A read only takes a word that has already crossed over.
  rd_avail_a: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_en_mem |-> (rd_count != '0)
  );

endmodule

//--- rtl/fifo_wr_ctrl.sv
`timescale 1ns/1ps
`include "async_fifo_consts.svh"

module fifo_wr_ctrl #(
  parameter int AFULL_LEVEL = `FIFO_AFULL_LEVEL
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  async_fifo_pkg::ptr_t  rd_ptr_gray,
  output logic                  wr_en_mem,
  output async_fifo_pkg::addr_t wr_addr,
  output async_fifo_pkg::ptr_t  wr_ptr_gray,
  output logic                  full,
  output logic                  afull
);

  localparam int TOP = `FIFO_ADDR_WIDTH;

  async_fifo_pkg::ptr_t wr_bin;
  async_fifo_pkg::ptr_t wr_bin_next;
  async_fifo_pkg::ptr_t wr_gray_next;
  async_fifo_pkg::ptr_t rd_gray_sync [`FIFO_SYNC_STAGES];
  async_fifo_pkg::ptr_t rd_gray_synced;
  async_fifo_pkg::ptr_t rd_bin_synced;
  async_fifo_pkg::ptr_t full_gray;
  async_fifo_pkg::ptr_t count_next;
  async_fifo_pkg::ptr_t wr_count;
  logic                 full_next;
  logic                 afull_next;

  // Writes while full are dropped.
  assign wr_en_mem    = wr_en && !full;
  assign wr_addr      = wr_bin[TOP-1:0];
  assign wr_bin_next  = wr_bin + async_fifo_pkg::ptr_t'(wr_en_mem);
  assign wr_gray_next = async_fifo_pkg::bin2gray(wr_bin_next);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_bin      <= wr_bin_next;
      wr_ptr_gray <= wr_gray_next;
    end
  end

  // Read pointer into this domain.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      for (int i = 0; i < `FIFO_SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= '0;
      end
    end else begin
      rd_gray_sync[0] <= rd_ptr_gray;
      for (int i = 1; i < `FIFO_SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= rd_gray_sync[i-1];
      end
    end
  end

  assign rd_gray_synced = rd_gray_sync[`FIFO_SYNC_STAGES-1];
  assign rd_bin_synced  = async_fifo_pkg::gray2bin(rd_gray_synced);

  // One lap ahead means the top two Gray bits are flipped.
  assign full_gray  = {~rd_gray_synced[TOP -: 2], rd_gray_synced[TOP-2:0]};
  assign full_next  = (wr_gray_next == full_gray);
  assign count_next = wr_bin_next - rd_bin_synced;
  assign afull_next = (count_next >= async_fifo_pkg::ptr_t'(AFULL_LEVEL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_next;
      afull <= afull_next;
    end
  end

  // Occupancy as seen from this side right now.
  assign wr_count = wr_bin - rd_bin_synced;

  wr_gray_step_a: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1
  );

  // A write never lands on a slot the reader still owns.
  wr_room_a: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    wr_en_mem |-> (wr_count < async_fifo_pkg::ptr_t'(`FIFO_DEPTH))
  );

endmodule
